// ==== tb.f ====
+incdir+.
riscvPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
riscvCore.sv
tbRefModel.sv
tbRiscvCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbRiscvCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0 --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -qx 'Result: PASSED' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tbRiscvCore.sv ====
// Testbench top with clock, reset, memories, LCG program generator, checks and watchdog
`include "riscvCfg.svh"

module tbRiscvCore import riscvPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod     = 8;
  localparam int ResetCycles   = 16;
  localparam int ProgLen       = 200;
  localparam int TimeoutCycles = ProgLen * 4 + 100;

  logic        clk;
  logic        arstN;
  xlenT        pcF;
  instrT       instrF;
  xlenT        dataAddr;
  xlenT        writeData;
  logic        memWrite;
  xlenT        readData;
  logic        retireValid;
  retireT      retire;

  instrT       imem [256];
  xlenT        dmem [64];
  logic [31:0] lcgState;
  int          sinceReset = 0;
  int          retireCount = 0;
  int          storeCount = 0;

  riscvCore i_riscvCore (
    .clk(clk), .arstN(arstN), .pcF(pcF), .instrF(instrF),
    .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .readData(readData),
    .retireValid(retireValid), .retire(retire)
  );

  tbRefModel i_refModel ();

  //////////////////////////////
  // Program generation
  //////////////////////////////

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic instrT encR(input regIdxT rd, input logic [2:0] f3, input regIdxT rs1,
                                 input regIdxT rs2, input logic [6:0] f7);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic instrT encI(input logic [6:0] op, input regIdxT rd, input logic [2:0] f3,
                                 input regIdxT rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  // SW with base x0
  function automatic instrT encS(input regIdxT rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic instrT encB(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
                                 input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic instrT encJ(input regIdxT rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
  endfunction

  // One random instruction placed at byte address pc
  function automatic instrT genInstr(input xlenT pc);
    logic [31:0] r;
    logic [31:0] s;
    regIdxT      rd;
    regIdxT      rs1;
    regIdxT      rs2;
    logic [2:0]  f3;
    logic [12:0] off;
    xlenT        tgt;
    r   = lcgNext();
    s   = lcgNext();
    // Upper LCG bits only, registers x0 to x7
    rd  = {2'b00, r[18:16]};
    rs1 = {2'b00, r[21:19]};
    rs2 = {2'b00, r[24:22]};
    // SLTU slot folds onto ADD
    f3  = (s[18:16] == 3'b011) ? 3'b000 : s[18:16];
    // Forward skip over one or two instructions
    off = r[25] ? 13'd12 : 13'd8;
    tgt = pc + {19'b0, off};
    case (r[29:26])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
        return encR(rd, f3, rs1, rs2, (f3 == 3'b000 && s[19]) ? 7'h20 : 7'h00);
      // Shift immediates keep funct7 clear
      4'd5, 4'd6, 4'd7, 4'd8:
        return encI(7'h13, rd, f3, rs1, (f3[1:0] == 2'b01) ? {7'h00, s[24:20]} : s[31:20]);
      4'd9:
        return {s[31:12], rd, 7'h37};
      // Word addresses 0 to 252 off x0
      4'd10, 4'd11:
        return encI(7'h03, rd, 3'b010, 5'd0, {4'h0, s[27:22], 2'b00});
      4'd12:
        return encS(rs2, {4'h0, s[27:22], 2'b00});
      4'd13:
        return encB(s[20] ? 3'b001 : 3'b000, rs1, rs2, off);
      4'd14:
        return encJ(rd, {8'h00, off});
      // JALR off x0 to an absolute forward target
      default:
        return encI(7'h67, rd, 3'b000, 5'd0, tgt[11:0]);
    endcase
  endfunction

  // Data image, every word address gives its own value
  function automatic xlenT fillWord(input int idx);
    return (32'h9E37_79B9 * xlenT'(idx + 1)) ^ xlenT'(idx << 20);
  endfunction

  //////////////////////////////
  // Memories
  //////////////////////////////

  // Fetch past the image returns a NOP
  assign instrF   = (pcF < 32'd1024) ? imem[pcF[9:2]] : `NOP_INSTR;
  assign readData = dmem[dataAddr[7:2]];

  // Stores land on the rising edge
  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAddr[7:2]] <= writeData;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkRetire(input string name, input retireT exp, input retireT act);
    if (act !== exp)
      stopRun($sformatf("** Error %s: expected x%0d=%h, actual x%0d=%h",
                        name, exp.rd, exp.result, act.rd, act.result));
  endtask

  task automatic checkStore(input string name, input xlenT expAddr, input xlenT expData,
                            input xlenT actAddr, input xlenT actData);
    if (actAddr !== expAddr || actData !== expData)
      stopRun($sformatf("** Error %s: expected [%h]=%h, actual [%h]=%h",
                        name, expAddr, expData, actAddr, actData));
  endtask

  task automatic checkPc(input string name, input xlenT exp, input xlenT act);
    if (act !== exp)
      stopRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp)
      stopRun($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
  endtask

  // Retire and store monitor, sampled before the edge updates
  always @(posedge clk) begin
    if (arstN) begin
      // Nothing reaches writeback in the first four cycles
      if ((retireValid || memWrite) && sinceReset < 4)
        stopRun("Retire or store seen before the first instruction reached writeback");
      if (retireValid) begin
        if (i_refModel.expRetire.size() == 0)
          stopRun("A register write retired when the model expected none");
        else
          checkRetire($sformatf("retire %0d", retireCount), i_refModel.expRetire.pop_front(),
                      retire);
        retireCount <= retireCount + 1;
      end
      if (memWrite) begin
        if (i_refModel.expStoreAddr.size() == 0)
          stopRun("A store reached the data port when the model expected none");
        else
          checkStore($sformatf("store %0d", storeCount), i_refModel.expStoreAddr.pop_front(),
                     i_refModel.expStoreData.pop_front(), dataAddr, writeData);
        storeCount <= storeCount + 1;
      end
      sinceReset <= sinceReset + 1;
    end
  end

  //////////////////////////////
  // Clock, stimulus, watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    logic [31:0] w;
    arstN    = 1'b0;
    lcgState = 32'd97;
    // Prologue gives x1 to x7 known values
    for (int i = 0; i < 256; i++) begin
      if (i < 7) begin
        w       = lcgNext();
        imem[i] = encI(7'h13, regIdxT'(i + 1), 3'b000, 5'd0, w[31:20]);
      end else if (i < ProgLen) begin
        imem[i] = genInstr(xlenT'(i * 4));
      end else begin
        imem[i] = `NOP_INSTR;
      end
      i_refModel.prog[i] = imem[i];
    end
    // Same data image for the DUT memory and the model
    for (int i = 0; i < 64; i++) begin
      dmem[i]            <= fillWord(i);
      i_refModel.dmem[i] = fillWord(i);
    end
    i_refModel.runProgram(ProgLen);
    repeat (ResetCycles) @(posedge clk);
    checkPc("reset pcF", `RESET_PC, pcF);
    checkFlag("reset memWrite", 1'b0, memWrite);
    checkFlag("reset retireValid", 1'b0, retireValid);
    arstN <= 1'b1;
    while (i_refModel.expRetire.size() != 0 || i_refModel.expStoreAddr.size() != 0)
      @(posedge clk);
    // Drain so a stray late retire or store is still caught
    repeat (20) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    stopRun($sformatf("Timeout: %0d retires and %0d stores still expected",
                      i_refModel.expRetire.size(), i_refModel.expStoreAddr.size()));
  end

endmodule

// ==== tbRefModel.sv ====
// Instruction-set reference model producing the expected retire and store streams
module tbRefModel import riscvPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // Program image and initial data image, loaded by the testbench top
  instrT  prog [256];
  xlenT   dmem [64];

  // Expected events in program order
  retireT expRetire [$];
  xlenT   expStoreAddr [$];
  xlenT   expStoreData [$];

  //////////////////////////////
  // Sequential ISA execution
  //////////////////////////////

  // Runs from address 0 until control leaves the program
  task automatic runProgram(input int progLen);
    xlenT   x [32];
    xlenT   pc;
    xlenT   nextPc;
    xlenT   val;
    xlenT   addr;
    xlenT   opB;
    xlenT   immI;
    xlenT   immS;
    xlenT   immB;
    xlenT   immJ;
    instrT  ins;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    logic   wr;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc = '0;
    while (pc < xlenT'(progLen * 4)) begin
      ins    = prog[pc[9:2]];
      rd     = ins[11:7];
      rs1    = ins[19:15];
      rs2    = ins[24:20];
      // Immediate formats as the ISA defines them
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      nextPc = pc + 32'd4;
      wr     = 1'b0;
      val    = '0;
      addr   = '0;
      // Register form takes rs2, immediate form takes immI
      opB    = (ins[6:0] == 7'h33) ? x[rs2] : immI;
      case (ins[6:0])
        7'h33, 7'h13: begin
          wr = 1'b1;
          case (ins[14:12])
            3'b000:  val = (ins[6:0] == 7'h33 && ins[30]) ? x[rs1] - opB : x[rs1] + opB;
            3'b001:  val = x[rs1] << opB[4:0];
            3'b010:  val = {31'b0, $signed(x[rs1]) < $signed(opB)};
            3'b100:  val = x[rs1] ^ opB;
            3'b101:  val = x[rs1] >> opB[4:0];
            3'b110:  val = x[rs1] | opB;
            default: val = x[rs1] & opB;
          endcase
        end
        // LUI
        7'h37: begin
          wr  = 1'b1;
          val = {ins[31:12], 12'b0};
        end
        // LW
        7'h03: begin
          wr   = 1'b1;
          addr = x[rs1] + immI;
          val  = dmem[addr[7:2]];
        end
        // SW updates the image so later loads see it
        7'h23: begin
          addr = x[rs1] + immS;
          dmem[addr[7:2]] = x[rs2];
          expStoreAddr.push_back(addr);
          expStoreData.push_back(x[rs2]);
        end
        // BEQ when funct3 bit 0 is clear, BNE when set
        7'h63: begin
          if ((x[rs1] == x[rs2]) != ins[12])
            nextPc = pc + immB;
        end
        7'h6F: begin
          wr     = 1'b1;
          val    = pc + 32'd4;
          nextPc = pc + immJ;
        end
        // JALR, bit 0 of target dropped
        7'h67: begin
          wr     = 1'b1;
          val    = pc + 32'd4;
          addr   = x[rs1] + immI;
          nextPc = {addr[31:1], 1'b0};
        end
        default: ;
      endcase
      // x0 stays zero and its writes are no events
      if (wr && rd != '0) begin
        x[rd] = val;
        expRetire.push_back('{rd: rd, result: val});
      end
      pc = nextPc;
    end
  endtask

endmodule

// ==== riscvCore.sv ====
// Top level with fetch, decode, execute, memory/writeback stages and hazard unit
module riscvCore import riscvPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  output xlenT   pcF,
  input  instrT  instrF,
  output xlenT   dataAddr,
  output xlenT   writeData,
  output logic   memWrite,
  input  xlenT   readData,
  output logic   retireValid,
  output retireT retire
);

  // Stage boundaries
  fetchDecT fetchDec;
  decExT    decEx;
  exMemT    exMem;

  // Hazard control
  regIdxT rs1D, rs2D;
  logic   stallF, stallD, flushD, flushE;
  fwdSelT fwdA, fwdB;

  // Redirect and writeback
  logic   pcSrc;
  xlenT   pcTarget;
  xlenT   memResult;
  logic   wbRegWrite;
  regIdxT wbRd;
  xlenT   wbResult;

  fetchStage i_fetchStage (
    .clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .pcSrc(pcSrc), .pcTarget(pcTarget), .instrF(instrF), .pcF(pcF), .fetchDec(fetchDec)
  );

  decodeStage i_decodeStage (
    .clk(clk), .arstN(arstN), .flushE(flushE), .fetchDec(fetchDec),
    .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbResult(wbResult),
    .rs1D(rs1D), .rs2D(rs2D), .decEx(decEx)
  );

  executeStage i_executeStage (
    .clk(clk), .arstN(arstN), .decEx(decEx), .fwdA(fwdA), .fwdB(fwdB),
    .memResult(memResult), .wbResult(wbResult),
    .pcSrc(pcSrc), .pcTarget(pcTarget), .exMem(exMem)
  );

  memWbStage i_memWbStage (
    .clk(clk), .arstN(arstN), .exMem(exMem), .readData(readData),
    .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .memResult(memResult),
    .wbRegWrite(wbRegWrite), .wbRd(wbRd), .wbResult(wbResult),
    .retireValid(retireValid), .retire(retire)
  );

  hazardUnit i_hazardUnit (
    .rs1D(rs1D), .rs2D(rs2D), .decEx(decEx), .exMem(exMem),
    .wbRegWrite(wbRegWrite), .wbRd(wbRd), .pcSrc(pcSrc),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
    .fwdA(fwdA), .fwdB(fwdB)
  );

endmodule

// ==== hazardUnit.sv ====
// Forwarding selects, load-use stall and branch flush control
module hazardUnit import riscvPkg::*; (
  input  regIdxT rs1D,
  input  regIdxT rs2D,
  input  decExT  decEx,
  input  exMemT  exMem,
  input  logic   wbRegWrite,
  input  regIdxT wbRd,
  input  logic   pcSrc,
  output logic   stallF,
  output logic   stallD,
  output logic   flushD,
  output logic   flushE,
  output fwdSelT fwdA,
  output fwdSelT fwdB
);

  logic loadUse;

  // Youngest producer wins, x0 never forwarded
  function automatic fwdSelT fwdPick(input regIdxT rs, input exMemT mem,
                                     input logic wbWe, input regIdxT wbDst);
    if (rs != '0 && mem.regWrite && mem.rd == rs)
      return fwdMem;
    if (rs != '0 && wbWe && wbDst == rs)
      return fwdWb;
    return fwdReg;
  endfunction

  always_comb begin
    fwdA = fwdPick(decEx.rs1, exMem, wbRegWrite, wbRd);
    fwdB = fwdPick(decEx.rs2, exMem, wbRegWrite, wbRd);
  end

  //////////////////////////////
  // Stall and flush
  //////////////////////////////

  // Load in execute feeding the instruction in decode
  assign loadUse = decEx.memRead && (decEx.rd != '0) &&
                   ((decEx.rd == rs1D) || (decEx.rd == rs2D));

  assign stallF = loadUse;
  assign stallD = loadUse;
  // Taken redirect squashes decode and execute
  assign flushD = pcSrc;
  assign flushE = loadUse || pcSrc;

  // A load and a redirect never sit in execute together
  always_comb begin
    a_stallFlushExcl: assert final (!(stallD && flushD));
  end

endmodule

// ==== memWbStage.sv ====
// Data memory port, memory/writeback register, result select and retire port
module memWbStage import riscvPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  exMemT  exMem,
  input  xlenT   readData,
  output xlenT   dataAddr,
  output xlenT   writeData,
  output logic   memWrite,
  output xlenT   memResult,
  output logic   wbRegWrite,
  output regIdxT wbRd,
  output xlenT   wbResult,
  output logic   retireValid,
  output retireT retire
);

  resultSrcT resultSrcW;
  xlenT      aluW;
  xlenT      readW;

  // Data port straight from the execute/memory register
  assign dataAddr  = exMem.aluResult;
  assign writeData = exMem.storeData;
  assign memWrite  = exMem.memWrite;

  // Forwarded value, link address for jumps
  assign memResult = (exMem.resultSrc == resPc4) ? exMem.pcPlus4 : exMem.aluResult;

  //////////////////////////////
  // Memory/writeback register
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbRegWrite <= 1'b0;
      wbRd       <= '0;
      resultSrcW <= resAlu;
    end else begin
      wbRegWrite <= exMem.regWrite;
      wbRd       <= exMem.rd;
      resultSrcW <= exMem.resultSrc;
    end
  end

  // Result payload, load data only captured on a load
  always_ff @(posedge clk) begin
    aluW <= memResult;
    if (exMem.memRead)
      readW <= readData;
  end

  // Writeback select
  assign wbResult    = (resultSrcW == resMem) ? readW : aluW;

  // Retire port, x0 writes are not events
  assign retireValid = wbRegWrite && (wbRd != '0);
  assign retire      = '{rd: wbRd, result: wbResult};

endmodule

// ==== executeStage.sv ====
// Forwarding muxes, ALU, branch compare, target adder and execute/memory register
`include "riscvCfg.svh"

module executeStage import riscvPkg::*; (
  input  logic   clk,
  input  logic   arstN,
  input  decExT  decEx,
  input  fwdSelT fwdA,
  input  fwdSelT fwdB,
  input  xlenT   memResult,
  input  xlenT   wbResult,
  output logic   pcSrc,
  output xlenT   pcTarget,
  output exMemT  exMem
);

  xlenT srcA;
  xlenT fwdValB;
  xlenT srcB;
  xlenT aluResult;
  xlenT regTarget;
  logic taken;

  // Operand forwarding
  always_comb begin
    case (fwdA)
      fwdMem:  srcA = memResult;
      fwdWb:   srcA = wbResult;
      default: srcA = decEx.rs1Val;
    endcase
    case (fwdB)
      fwdMem:  fwdValB = memResult;
      fwdWb:   fwdValB = wbResult;
      default: fwdValB = decEx.rs2Val;
    endcase
  end

  assign srcB = decEx.aluSrcB ? decEx.imm : fwdValB;

  // ALU, shifts use the low five bits
  always_comb begin
    case (decEx.aluOp)
      aluSub:   aluResult = srcA - srcB;
      aluAnd:   aluResult = srcA & srcB;
      aluOr:    aluResult = srcA | srcB;
      aluXor:   aluResult = srcA ^ srcB;
      aluSlt:   aluResult = xlenT'($signed(srcA) < $signed(srcB));
      aluSll:   aluResult = srcA << srcB[4:0];
      aluSrl:   aluResult = srcA >> srcB[4:0];
      aluPassB: aluResult = srcB;
      default:  aluResult = srcA + srcB;
    endcase
  end

  //////////////////////////////
  // Branch resolution
  //////////////////////////////

  // Equality inverted for BNE
  assign taken     = decEx.branch && ((srcA == fwdValB) ^ decEx.branchNe);
  assign pcSrc     = taken || decEx.jump;
  // JALR clears bit 0 of the target
  assign regTarget = srcA + decEx.imm;
  assign pcTarget  = decEx.jumpReg ? {regTarget[`XLEN-1:1], 1'b0} : decEx.pc + decEx.imm;

  // Execute/memory register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem.regWrite  <= decEx.regWrite;
      exMem.memWrite  <= decEx.memWrite;
      exMem.memRead   <= decEx.memRead;
      exMem.resultSrc <= decEx.resultSrc;
      exMem.rd        <= decEx.rd;
      exMem.aluResult <= aluResult;
      exMem.storeData <= fwdValB;
      exMem.pcPlus4   <= decEx.pcPlus4;
    end
  end

  // A jump never becomes a store at the data port
  a_jumpNoStore: assert property (@(posedge clk) disable iff (!arstN)
    decEx.jump |=> !exMem.memWrite);

endmodule

// ==== decodeStage.sv ====
// Instruction decoder, register file, immediate extender and decode/execute register
module decodeStage import riscvPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     flushE,
  input  fetchDecT fetchDec,
  input  logic     wbRegWrite,
  input  regIdxT   wbRd,
  input  xlenT     wbResult,
  output regIdxT   rs1D,
  output regIdxT   rs2D,
  output decExT    decEx
);

  instrT      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  immSrcT     immSrc;
  xlenT       immD;
  xlenT       rs1ValD;
  xlenT       rs2ValD;
  decExT      decExD;
  xlenT       rf [32];

  // ALU operation from funct3, subOp only set for R-type SUB
  function automatic aluOpT aluDecode(input logic [2:0] f3, input logic subOp);
    case (f3)
      3'b000:  return subOp ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b100:  return aluXor;
      3'b101:  return aluSrl;
      3'b110:  return aluOr;
      3'b111:  return aluAnd;
      default: return aluAdd;
    endcase
  endfunction

  assign instr  = fetchDec.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1D   = instr[19:15];
  assign rs2D   = instr[24:20];

  //////////////////////////////
  // Control decode
  //////////////////////////////

  always_comb begin
    decExD = '0;
    immSrc = immI;
    case (opcode)
      // R-type register ops
      7'b0110011: begin
        decExD.regWrite = 1'b1;
        decExD.aluOp    = aluDecode(funct3, instr[30]);
      end
      // Immediate ops, no subtract form
      7'b0010011: begin
        decExD.regWrite = 1'b1;
        decExD.aluSrcB  = 1'b1;
        decExD.aluOp    = aluDecode(funct3, 1'b0);
      end
      7'b0110111: begin
        immSrc          = immU;
        decExD.regWrite = 1'b1;
        decExD.aluSrcB  = 1'b1;
        decExD.aluOp    = aluPassB;
      end
      // LW
      7'b0000011: begin
        decExD.regWrite  = 1'b1;
        decExD.aluSrcB   = 1'b1;
        decExD.memRead   = 1'b1;
        decExD.resultSrc = resMem;
      end
      // SW
      7'b0100011: begin
        immSrc          = immS;
        decExD.aluSrcB  = 1'b1;
        decExD.memWrite = 1'b1;
      end
      // BEQ, BNE picked by funct3 bit 0
      7'b1100011: begin
        immSrc          = immB;
        decExD.branch   = 1'b1;
        decExD.branchNe = funct3[0];
      end
      7'b1101111: begin
        immSrc           = immJ;
        decExD.regWrite  = 1'b1;
        decExD.jump      = 1'b1;
        decExD.resultSrc = resPc4;
      end
      // JALR, target from rs1
      7'b1100111: begin
        decExD.regWrite  = 1'b1;
        decExD.jump      = 1'b1;
        decExD.jumpReg   = 1'b1;
        decExD.resultSrc = resPc4;
      end
      default: ;
    endcase
    decExD.rs1     = rs1D;
    decExD.rs2     = rs2D;
    decExD.rd      = instr[11:7];
    decExD.rs1Val  = rs1ValD;
    decExD.rs2Val  = rs2ValD;
    decExD.imm     = immD;
    decExD.pc      = fetchDec.pc;
    decExD.pcPlus4 = fetchDec.pcPlus4;
  end

  // Immediate extender
  always_comb begin
    case (immSrc)
      immI:    immD = {{20{instr[31]}}, instr[31:20]};
      immS:    immD = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      immB:    immD = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      immU:    immD = {instr[31:12], 12'b0};
      default: immD = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endcase
  end

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Writeback port, x0 cleared on reset and never written
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (wbRegWrite && wbRd != '0) begin
      rf[wbRd] <= wbResult;
    end
  end

  // Read ports bypass the same-cycle write
  assign rs1ValD = (wbRegWrite && wbRd != '0 && wbRd == rs1D) ? wbResult : rf[rs1D];
  assign rs2ValD = (wbRegWrite && wbRd != '0 && wbRd == rs2D) ? wbResult : rf[rs2D];

  // Decode/execute register, bubble on flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decEx <= '0;
    end else if (flushE) begin
      decEx <= '0;
    end else begin
      decEx <= decExD;
    end
  end

  // x0 reaches execute as zero
  a_x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
    rs1D == '0 |=> decEx.rs1Val == '0);

endmodule

// ==== fetchStage.sv ====
// PC register, next-PC select and fetch/decode instruction register
`include "riscvCfg.svh"

module fetchStage import riscvPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     stallF,
  input  logic     stallD,
  input  logic     flushD,
  input  logic     pcSrc,
  input  xlenT     pcTarget,
  input  instrT    instrF,
  output xlenT     pcF,
  output fetchDecT fetchDec
);

  xlenT pcPlus4F;
  xlenT pcNext;

  assign pcPlus4F = pcF + xlenT'(4);
  // Redirect from execute wins over sequential fetch
  assign pcNext   = pcSrc ? pcTarget : pcPlus4F;

  // PC holds while a load-use bubble drains
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= `RESET_PC;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

  // Fetch/decode register, squashed slot becomes a NOP
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fetchDec <= '{instr: `NOP_INSTR, pc: '0, pcPlus4: '0};
    end else if (flushD) begin
      fetchDec <= '{instr: `NOP_INSTR, pc: '0, pcPlus4: '0};
    end else if (!stallD) begin
      fetchDec <= '{instr: instrF, pc: pcF, pcPlus4: pcPlus4F};
    end
  end

endmodule

// ==== riscvPkg.sv ====
// Width typedefs, operation enums and stage-boundary structs
`include "riscvCfg.svh"

package riscvPkg;

  // Widths that carry a meaning
  typedef logic [`XLEN-1:0] xlenT;
  typedef logic [31:0]      instrT;
  typedef logic [4:0]       regIdxT;

  //////////////////////////////
  // Operation encodings
  //////////////////////////////

  // ALU operations, passB serves LUI
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluPassB
  } aluOpT;

  // Immediate formats
  typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSrcT;

  // Writeback source
  typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSrcT;

  // Operand source in execute
  typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

  //////////////////////////////
  // Stage boundaries
  //////////////////////////////

  typedef struct packed {
    instrT instr;
    xlenT  pc;
    xlenT  pcPlus4;
  } fetchDecT;

  typedef struct packed {
    aluOpT     aluOp;
    logic      aluSrcB;
    logic      regWrite;
    logic      memWrite;
    logic      memRead;
    resultSrcT resultSrc;
    logic      branch;
    logic      branchNe;
    logic      jump;
    logic      jumpReg;
    regIdxT    rs1;
    regIdxT    rs2;
    regIdxT    rd;
    xlenT      rs1Val;
    xlenT      rs2Val;
    xlenT      imm;
    xlenT      pc;
    xlenT      pcPlus4;
  } decExT;

  typedef struct packed {
    logic      regWrite;
    logic      memWrite;
    logic      memRead;
    resultSrcT resultSrc;
    regIdxT    rd;
    xlenT      aluResult;
    xlenT      storeData;
    xlenT      pcPlus4;
  } exMemT;

  // One retired register write
  typedef struct packed {
    regIdxT rd;
    xlenT   result;
  } retireT;

endpackage

// ==== riscvCfg.svh ====
// Core width, reset fetch address and bubble instruction encoding
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

//////////////////////////////
// Core configuration
//////////////////////////////

// Data and address width
`define XLEN 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0 fills squashed fetch/decode slots
`define NOP_INSTR 32'h0000_0013

`endif
